// ==== Makefile ====
TOOL = verilator
FLAGS = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP = tb_dtim
FILELIST = vlog.f
LOG = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== logic/dtim_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module dtim_decode #(
  parameter int ways = 4,
  parameter int depth = 16,
  parameter dtim_pkg::word_t base_addr = 32'h0000_0000,
  parameter dtim_pkg::word_t top_addr = 32'h0000_1000
) (
  input logic clock,
  input logic reset,
  input logic req_valid,
  input logic req_fence,
  input dtim_pkg::word_t req_addr,
  input dtim_pkg::word_t req_wdata,
  input dtim_pkg::strb_t req_wstrb,
  output logic [$clog2(depth)-1:0] ram_raddr,
  dtim_req_if.decode req
);

  localparam int way_w = $clog2(ways);
  localparam int idx_w = $clog2(depth);
  localparam int tag_w = dtim_pkg::tag_width(ways, depth);

  dtim_pkg::word_t aligned;
  logic in_window;

  assign aligned = {req_addr[31:2], 2'b00};
  assign in_window = (aligned >= base_addr) && (aligned < top_addr);

  // every way is read at the incoming index so the entry is ready with the request.
  assign ram_raddr = req_addr[idx_w+way_w+1:way_w+2];

  always_ff @(posedge clock) begin
    if (!reset) begin
      req.valid <= 1'b0;
    end else begin
      req.valid <= req_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid) begin
      req.fence <= req_fence;
      req.write <= |req_wstrb;
      req.strb <= req_wstrb;
      req.wdata <= req_wdata;
      req.addr <= aligned;
      req.tag <= req_addr[31:32-tag_w];
      req.index <= req_addr[idx_w+way_w+1:way_w+2];
      req.way <= req_addr[way_w+1:2];
      req.in_window <= in_window;
    end
  end

endmodule

`default_nettype wire

// ==== logic/dtim_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module dtim_execute #(
  parameter int ways = 4,
  parameter int depth = 16
) (
  input logic clock,
  input logic reset,
  dtim_req_if.execute req,
  input logic [$clog2(depth)-1:0] ram_raddr,
  dtim_ram_if.ctrl ram [ways],
  output logic mem_valid,
  output dtim_pkg::word_t mem_addr,
  output dtim_pkg::word_t mem_wdata,
  output dtim_pkg::strb_t mem_wstrb,
  input logic mem_ready,
  input dtim_pkg::word_t mem_rdata,
  output logic rsp_ready,
  output dtim_pkg::word_t rsp_rdata
);

  localparam int way_w = $clog2(ways);
  localparam int idx_w = $clog2(depth);
  localparam int tag_w = dtim_pkg::tag_width(ways, depth);
  localparam int entry_w = dtim_pkg::entry_width(ways, depth);
  localparam int lock_pos = dtim_pkg::lock_bit(ways, depth);
  localparam int dirty_pos = dtim_pkg::dirty_bit(ways, depth);

  dtim_pkg::dtim_state_e state, state_d;
  logic [way_w-1:0] walk_way, walk_way_d, step_way, sel_way, wr_way;
  // steps through the indices while reset is held so every way is cleared.
  logic [idx_w-1:0] walk_index = '0;
  logic [idx_w-1:0] walk_index_d, step_index, wr_index, raddr_sel;
  logic walk_last, walk_advance;
  logic [entry_w-1:0] way_rdata [ways];
  logic [entry_w-1:0] entry, wr_entry;
  logic [ways-1:0] wen_vec;
  logic wr_en;
  logic entry_lock, entry_dirty;
  logic [tag_w-1:0] entry_tag;
  dtim_pkg::word_t entry_data;
  logic mem_valid_d, rsp_ready_d;
  dtim_pkg::word_t mem_addr_d, mem_wdata_d, rsp_rdata_d;
  dtim_pkg::strb_t mem_wstrb_d;

  function automatic dtim_pkg::word_t merge_bytes(dtim_pkg::word_t base,
                                                  dtim_pkg::word_t data,
                                                  dtim_pkg::strb_t strb);
    dtim_pkg::word_t result;
    result = base;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = data[8*b +: 8];
      end
    end
    return result;
  endfunction

  for (genvar w = 0; w < ways; w++) begin : g_way
    assign way_rdata[w] = ram[w].rdata;
    assign wen_vec[w] = !reset || (wr_en && wr_way == way_w'(w));
    assign ram[w].wen = wen_vec[w];
    assign ram[w].waddr = wr_index;
    assign ram[w].wdata = wr_entry;
    assign ram[w].raddr = raddr_sel;
  end

  assign sel_way = (state == dtim_pkg::fence) ? walk_way : req.way;
  assign entry = way_rdata[sel_way];
  assign entry_lock = entry[lock_pos];
  assign entry_dirty = entry[dirty_pos];
  assign entry_tag = entry[dirty_pos-1:32];
  assign entry_data = entry[31:0];

  // the walk runs way by way within an index.
  assign step_way = walk_way + way_w'(1);
  assign step_index = (&walk_way) ? walk_index + idx_w'(1) : walk_index;
  assign walk_last = (&walk_way) && (&walk_index);
  assign raddr_sel = (state_d == dtim_pkg::fence) ? walk_index_d : ram_raddr;

  always_comb begin
    state_d = state;
    walk_way_d = walk_way;
    walk_index_d = walk_index;
    walk_advance = 1'b0;
    mem_valid_d = mem_valid;
    mem_addr_d = mem_addr;
    mem_wdata_d = mem_wdata;
    mem_wstrb_d = mem_wstrb;
    rsp_ready_d = 1'b0;
    rsp_rdata_d = rsp_rdata;
    wr_en = 1'b0;
    wr_way = walk_way;
    wr_index = walk_index;
    wr_entry = '0;
    case (state)
      dtim_pkg::idle: begin
        if (req.valid) begin
          if (req.fence) begin
            state_d = dtim_pkg::fence;
            walk_way_d = '0;
            walk_index_d = '0;
          end else if (!req.in_window || (entry_lock && entry_tag != req.tag)) begin
            state_d = dtim_pkg::bypass;
            mem_valid_d = 1'b1;
            mem_addr_d = req.addr;
            mem_wdata_d = req.wdata;
            mem_wstrb_d = req.strb;
          end else if (!entry_lock) begin
            state_d = dtim_pkg::miss;
            mem_valid_d = 1'b1;
            mem_addr_d = req.addr;
            mem_wdata_d = req.wdata;
            mem_wstrb_d = '0;
          end else begin
            rsp_ready_d = 1'b1;
            rsp_rdata_d = entry_data;
            wr_en = req.write;
            wr_way = req.way;
            wr_index = req.index;
            wr_entry = {1'b1, 1'b1, req.tag, merge_bytes(entry_data, req.wdata, req.strb)};
          end
        end
      end
      dtim_pkg::miss: begin
        if (mem_ready) begin
          state_d = dtim_pkg::idle;
          mem_valid_d = 1'b0;
          rsp_ready_d = 1'b1;
          rsp_rdata_d = mem_rdata;
          // fill the slot with store bytes laid over the fetched word.
          wr_en = 1'b1;
          wr_way = req.way;
          wr_index = req.index;
          wr_entry = {1'b1, req.write, req.tag, merge_bytes(mem_rdata, req.wdata, req.strb)};
        end
      end
      dtim_pkg::bypass: begin
        if (mem_ready) begin
          state_d = dtim_pkg::idle;
          mem_valid_d = 1'b0;
          rsp_ready_d = 1'b1;
          rsp_rdata_d = mem_rdata;
        end
      end
      dtim_pkg::fence: begin
        if (mem_valid) begin
          if (mem_ready) begin
            mem_valid_d = 1'b0;
            walk_advance = 1'b1;
          end
        end else if (entry_lock && entry_dirty) begin
          mem_valid_d = 1'b1;
          mem_addr_d = {entry_tag, walk_index, walk_way, 2'b00};
          mem_wdata_d = entry_data;
          mem_wstrb_d = 4'hf;
        end else begin
          walk_advance = 1'b1;
        end
        if (walk_advance) begin
          wr_en = 1'b1;
          walk_way_d = step_way;
          walk_index_d = step_index;
          if (walk_last) begin
            state_d = dtim_pkg::idle;
            rsp_ready_d = 1'b1;
          end
        end
      end
      default: begin
        state_d = dtim_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= dtim_pkg::idle;
      mem_valid <= 1'b0;
      rsp_ready <= 1'b0;
      walk_way <= '0;
      walk_index <= walk_index + idx_w'(1);
    end else begin
      state <= state_d;
      mem_valid <= mem_valid_d;
      rsp_ready <= rsp_ready_d;
      walk_way <= walk_way_d;
      walk_index <= walk_index_d;
    end
  end

  always_ff @(posedge clock) begin
    mem_addr <= mem_addr_d;
    mem_wdata <= mem_wdata_d;
    mem_wstrb <= mem_wstrb_d;
    rsp_rdata <= rsp_rdata_d;
  end

  // the core gets one answer per request and never two pulses in a row.
  a_rsp_single: assert property (@(posedge clock) disable iff (!reset)
    rsp_ready |=> !rsp_ready);

  a_mem_hold: assert property (@(posedge clock) disable iff (!reset)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) &&
      $stable(mem_wdata) && $stable(mem_wstrb));

  // the RAMs are left alone while a memory transfer is pending.
  a_no_write_while_waiting: assert property (@(posedge clock) disable iff (!reset)
    mem_valid && !mem_ready |-> !(|wen_vec));

endmodule

`default_nettype wire

// ==== logic/dtim_pkg.sv ====
`default_nettype none

package dtim_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0] strb_t;

  typedef enum logic [1:0] {
    idle = 2'd0,
    miss = 2'd1,
    bypass = 2'd2,
    fence = 2'd3
  } dtim_state_e;

  // a stored entry is {lock, dirty, tag, data}, data in the low 32 bits.
  // the way comes from the low word-address bits and the index from the bits above.
  function automatic int tag_width(int ways, int depth);
    return 30 - $clog2(ways) - $clog2(depth);
  endfunction

  function automatic int entry_width(int ways, int depth);
    return tag_width(ways, depth) + 34;
  endfunction

  function automatic int lock_bit(int ways, int depth);
    return entry_width(ways, depth) - 1;
  endfunction

  function automatic int dirty_bit(int ways, int depth);
    return entry_width(ways, depth) - 2;
  endfunction

endpackage

`default_nettype wire

// ==== logic/dtim_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module dtim_ram #(
  parameter int depth = 16,
  parameter int width = 58
) (
  input logic clock,
  dtim_ram_if.ram port
);

  logic [width-1:0] mem [depth];
  logic [$clog2(depth)-1:0] raddr_q;

  // read address is registered, so data follows one cycle after raddr.
  always_ff @(posedge clock) begin
    raddr_q <= port.raddr;
    if (port.wen) begin
      mem[port.waddr] <= port.wdata;
    end
  end

  assign port.rdata = mem[raddr_q];

endmodule

`default_nettype wire

// ==== logic/dtim_ram_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface dtim_ram_if #(
  parameter int ways = 4,
  parameter int depth = 16
);
  localparam int idx_w = $clog2(depth);
  localparam int entry_w = dtim_pkg::entry_width(ways, depth);

  logic wen;
  logic [idx_w-1:0] waddr;
  logic [entry_w-1:0] wdata;
  logic [idx_w-1:0] raddr;
  logic [entry_w-1:0] rdata;

  modport ctrl (output wen, waddr, wdata, raddr, input rdata);
  modport ram (input wen, waddr, wdata, raddr, output rdata);

endinterface

`default_nettype wire

// ==== logic/dtim_req_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface dtim_req_if #(
  parameter int ways = 4,
  parameter int depth = 16
);
  localparam int way_w = $clog2(ways);
  localparam int idx_w = $clog2(depth);
  localparam int tag_w = dtim_pkg::tag_width(ways, depth);

  logic valid;
  logic fence;
  logic write;
  dtim_pkg::strb_t strb;
  dtim_pkg::word_t wdata;
  dtim_pkg::word_t addr;
  logic [tag_w-1:0] tag;
  logic [idx_w-1:0] index;
  logic [way_w-1:0] way;
  logic in_window;

  modport decode (output valid, fence, write, strb, wdata, addr, tag, index, way, in_window);
  modport execute (input valid, fence, write, strb, wdata, addr, tag, index, way, in_window);

endinterface

`default_nettype wire

// ==== logic/dtim_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module dtim_top #(
  parameter int ways = 4,
  parameter int depth = 16,
  parameter dtim_pkg::word_t base_addr = 32'h0000_0000,
  parameter dtim_pkg::word_t top_addr = 32'h0000_1000
) (
  input logic clock,
  input logic reset,
  input logic req_valid,
  input logic req_fence,
  input dtim_pkg::word_t req_addr,
  input dtim_pkg::word_t req_wdata,
  input dtim_pkg::strb_t req_wstrb,
  output logic rsp_ready,
  output dtim_pkg::word_t rsp_rdata,
  output logic mem_valid,
  output dtim_pkg::word_t mem_addr,
  output dtim_pkg::word_t mem_wdata,
  output dtim_pkg::strb_t mem_wstrb,
  input logic mem_ready,
  input dtim_pkg::word_t mem_rdata
);

  localparam int entry_w = dtim_pkg::entry_width(ways, depth);

  logic [$clog2(depth)-1:0] ram_raddr;

  dtim_req_if #(.ways(ways), .depth(depth)) req_bus ();
  dtim_ram_if #(.ways(ways), .depth(depth)) ram_bus [ways] ();

  dtim_decode #(
    .ways(ways),
    .depth(depth),
    .base_addr(base_addr),
    .top_addr(top_addr)
  ) i_decode (
    .clock(clock),
    .reset(reset),
    .req_valid(req_valid),
    .req_fence(req_fence),
    .req_addr(req_addr),
    .req_wdata(req_wdata),
    .req_wstrb(req_wstrb),
    .ram_raddr(ram_raddr),
    .req(req_bus)
  );

  dtim_execute #(
    .ways(ways),
    .depth(depth)
  ) i_execute (
    .clock(clock),
    .reset(reset),
    .req(req_bus),
    .ram_raddr(ram_raddr),
    .ram(ram_bus),
    .mem_valid(mem_valid),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .mem_ready(mem_ready),
    .mem_rdata(mem_rdata),
    .rsp_ready(rsp_ready),
    .rsp_rdata(rsp_rdata)
  );

  for (genvar w = 0; w < ways; w++) begin : g_ram
    dtim_ram #(
      .depth(depth),
      .width(entry_w)
    ) i_ram (
      .clock(clock),
      .port(ram_bus[w])
    );
  end

endmodule

`default_nettype wire

// ==== verification/dtim_mem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module dtim_mem_model #(
  parameter int max_delay = 4
) (
  input logic clock,
  input logic reset,
  input logic mem_valid,
  input dtim_pkg::word_t mem_addr,
  input dtim_pkg::word_t mem_wdata,
  input dtim_pkg::strb_t mem_wstrb,
  output logic mem_ready,
  output dtim_pkg::word_t mem_rdata,
  output int write_count
);

  dtim_pkg::word_t store [dtim_pkg::word_t];
  logic ready_q = 1'b0;
  dtim_pkg::word_t rdata_q = '0;
  int writes = 0;
  int waited = 0;
  int delay = 0;

  assign mem_ready = ready_q;
  assign mem_rdata = rdata_q;
  assign write_count = writes;

  // untouched words hold a pattern of their own address.
  function automatic dtim_pkg::word_t preload_word(dtim_pkg::word_t addr);
    return ({2'b00, addr[31:2]} * 32'h9e37_79b9) ^ 32'h6b3c_19d5;
  endfunction

  function automatic dtim_pkg::word_t read_word(dtim_pkg::word_t addr);
    return store.exists(addr) ? store[addr] : preload_word(addr);
  endfunction

  always @(negedge clock) begin : respond
    dtim_pkg::word_t aligned;
    dtim_pkg::word_t merged;
    aligned = {mem_addr[31:2], 2'b00};
    if (!reset || ready_q) begin
      // the transfer was taken at the last rising edge.
      ready_q = 1'b0;
      waited = 0;
    end else if (mem_valid) begin
      if (waited == 0) begin
        delay = 1 + int'($urandom % max_delay);
      end
      waited++;
      if (waited >= delay) begin
        ready_q = 1'b1;
        rdata_q = read_word(aligned);
        if (|mem_wstrb) begin
          merged = rdata_q;
          for (int b = 0; b < 4; b++) begin
            if (mem_wstrb[b]) begin
              merged[8*b +: 8] = mem_wdata[8*b +: 8];
            end
          end
          store[aligned] = merged;
          writes++;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_dtim.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_dtim;

  localparam int ways = 4;
  localparam int depth = 16;
  localparam int slots = ways * depth;
  localparam int slot_w = $clog2(slots);
  localparam dtim_pkg::word_t base_addr = 32'h0000_1000;
  localparam dtim_pkg::word_t top_addr = 32'h0000_2000;
  localparam int max_delay = 4;
  localparam int directed_ops = 20;
  localparam int random_ops = 200;
  localparam int total_ops = directed_ops + random_ops;
  // a fence may wait on the slowest memory answer for every slot.
  localparam int fence_cycles = slots * (max_delay + 3);

  typedef struct packed {
    dtim_pkg::word_t addr;
    dtim_pkg::word_t data;
    dtim_pkg::strb_t strb;
  } xfer_t;

  typedef struct packed {
    logic check;
    dtim_pkg::word_t value;
  } rsp_t;

  logic clock;
  logic reset;
  logic req_valid;
  logic req_fence;
  dtim_pkg::word_t req_addr;
  dtim_pkg::word_t req_wdata;
  dtim_pkg::strb_t req_wstrb;
  logic rsp_ready;
  dtim_pkg::word_t rsp_rdata;
  logic mem_valid;
  logic mem_ready;
  dtim_pkg::word_t mem_addr;
  dtim_pkg::word_t mem_wdata;
  dtim_pkg::word_t mem_rdata;
  dtim_pkg::strb_t mem_wstrb;
  int write_count;

  dtim_pkg::word_t shadow [dtim_pkg::word_t];
  logic slot_lock [slots];
  logic slot_dirty [slots];
  dtim_pkg::word_t slot_tag [slots];
  xfer_t xfer_q [$];
  rsp_t rsp_q [$];
  int issued, issue_cycle, last_latency, expected_writes, stim_errors;
  int cycle, responded, rsp_cycle, xfer_done, mem_valid_cycles, errors;

  dtim_top #(
    .ways(ways),
    .depth(depth),
    .base_addr(base_addr),
    .top_addr(top_addr)
  ) i_dut (.*);

  dtim_mem_model #(.max_delay(max_delay)) i_mem (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic dtim_pkg::word_t initial_word(dtim_pkg::word_t addr);
    return ({2'b00, addr[31:2]} * 32'h9e37_79b9) ^ 32'h6b3c_19d5;
  endfunction

  function automatic dtim_pkg::word_t shadow_value(dtim_pkg::word_t addr);
    return shadow.exists(addr) ? shadow[addr] : initial_word(addr);
  endfunction

  // strobed lanes come from data, the others keep the old word.
  function automatic dtim_pkg::word_t merge_word(dtim_pkg::word_t old,
                                                 dtim_pkg::word_t data,
                                                 dtim_pkg::strb_t strb);
    dtim_pkg::word_t mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old & ~mask) | (data & mask);
  endfunction

  task automatic access(input logic is_fence, input dtim_pkg::word_t addr,
                        input dtim_pkg::word_t wdata, input dtim_pkg::strb_t strb);
    dtim_pkg::word_t waddr;
    dtim_pkg::word_t tag;
    dtim_pkg::word_t back;
    int slot;
    logic in_window;
    waddr = {addr[31:2], 2'b00};
    slot = int'(waddr[2 +: slot_w]);
    tag = waddr >> (2 + slot_w);
    in_window = (waddr >= base_addr) && (waddr < top_addr);
    if (is_fence) begin
      // the walk goes way by way within an index, which is plain slot order.
      for (int s = 0; s < slots; s++) begin
        if (slot_lock[s] && slot_dirty[s]) begin
          back = (slot_tag[s] << (2 + slot_w)) | (dtim_pkg::word_t'(s) << 2);
          xfer_q.push_back({back, shadow_value(back), 4'hf});
          expected_writes++;
        end
        slot_lock[s] = 1'b0;
        slot_dirty[s] = 1'b0;
      end
      rsp_q.push_back({1'b0, 32'h0});
    end else begin
      if (!in_window || (slot_lock[slot] && slot_tag[slot] != tag)) begin
        xfer_q.push_back({waddr, wdata, strb});
        expected_writes += int'(|strb);
      end else begin
        if (!slot_lock[slot]) begin
          xfer_q.push_back({waddr, wdata, 4'h0});
        end
        slot_lock[slot] = 1'b1;
        slot_tag[slot] = tag;
        slot_dirty[slot] = slot_dirty[slot] | (|strb);
      end
      rsp_q.push_back({!(|strb), shadow_value(waddr)});
      if (|strb) begin
        shadow[waddr] = merge_word(shadow_value(waddr), wdata, strb);
      end
    end
    req_addr = addr;
    req_wdata = wdata;
    req_wstrb = strb;
    req_fence = is_fence;
    req_valid = 1'b1;
    issue_cycle = cycle + 1;
    issued++;
    @(negedge clock);
    req_valid = 1'b0;
    while (responded != issued) begin
      @(negedge clock);
    end
    last_latency = rsp_cycle - issue_cycle;
  endtask

  task automatic check_hit(input int mem_cycles_before);
    if (last_latency != 2) begin
      stim_errors++;
      $display("%0t: hit answered after %0d cycles instead of 2", $time, last_latency);
    end
    if (mem_valid_cycles != mem_cycles_before) begin
      stim_errors++;
      $display("%0t: a hit raised mem_valid", $time);
    end
  endtask

  always @(posedge clock) begin : compare
    xfer_t x;
    rsp_t r;
    cycle++;
    if (mem_valid) begin
      mem_valid_cycles++;
      if (issued == responded) begin
        errors++;
        $display("%0t: mem_valid raised with no request outstanding", $time);
      end
    end
    if (mem_valid && mem_ready) begin
      if (xfer_done >= xfer_q.size()) begin
        errors++;
        $display("%0t: unexpected memory transfer to %h", $time, mem_addr);
      end else begin
        x = xfer_q[xfer_done];
        xfer_done++;
        if (mem_addr !== x.addr) begin
          errors++;
          $display("[ERROR] %0t mem_addr: got %h, expected %h", $time, mem_addr, x.addr);
        end
        if (mem_wstrb !== x.strb) begin
          errors++;
          $display("[ERROR] %0t mem_wstrb: got %h, expected %h", $time, mem_wstrb, x.strb);
        end
        if (|x.strb && mem_wdata !== x.data) begin
          errors++;
          $display("[ERROR] %0t mem_wdata: got %h, expected %h", $time, mem_wdata, x.data);
        end
      end
    end
    if (rsp_ready) begin
      rsp_cycle = cycle;
      if (responded >= rsp_q.size()) begin
        errors++;
        $display("%0t: rsp_ready with no request outstanding", $time);
      end else begin
        r = rsp_q[responded];
        if (r.check && rsp_rdata !== r.value) begin
          errors++;
          $display("[ERROR] %0t rsp_rdata: got %h, expected %h", $time, rsp_rdata, r.value);
        end
      end
      responded++;
    end
  end

  initial begin
    #((16 + 10 + total_ops * fence_cycles) * 8);
    $display("watchdog expired before the test sequence finished");
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    dtim_pkg::word_t a, b, c, addr, wdata;
    dtim_pkg::strb_t strb;
    int hold, writes, kind;
    void'($urandom(32'h408dbe02));
    reset = 1'b0;
    req_valid = 1'b0;
    req_fence = 1'b0;
    req_addr = '0;
    req_wdata = '0;
    req_wstrb = '0;
    for (int s = 0; s < slots; s++) begin
      slot_lock[s] = 1'b0;
      slot_dirty[s] = 1'b0;
      slot_tag[s] = '0;
    end
    repeat (16) @(negedge clock);
    reset = 1'b1;
    // idle after reset, nothing may answer or reach memory.
    repeat (10) @(negedge clock);

    a = base_addr + 32'h10;
    b = base_addr + 32'h24;
    c = base_addr + 32'h38;
    access(1'b0, a, 32'h0, 4'h0);
    hold = mem_valid_cycles;
    access(1'b0, a, 32'h0, 4'h0);
    check_hit(hold);

    wdata = $urandom;
    strb = dtim_pkg::strb_t'(1 + $urandom % 14);
    hold = mem_valid_cycles;
    writes = write_count;
    access(1'b0, a, wdata, strb);
    check_hit(hold);
    access(1'b0, a, 32'h0, 4'h0);
    if (write_count != writes) begin
      stim_errors++;
      $display("%0t: a write to a locked slot reached memory", $time);
    end

    // outside the window, then a second tag on the slot of a.
    addr = top_addr + 32'h40;
    wdata = $urandom;
    access(1'b0, addr, 32'h0, 4'h0);
    access(1'b0, addr, wdata, dtim_pkg::strb_t'(1 + $urandom % 15));
    access(1'b0, addr, 32'h0, 4'h0);
    access(1'b0, base_addr - 32'h8, 32'h0, 4'h0);
    addr = a + dtim_pkg::word_t'(slots * 4);
    access(1'b0, addr, $urandom, 4'hf);
    access(1'b0, addr, 32'h0, 4'h0);

    access(1'b0, b, $urandom, 4'h6);
    access(1'b0, c, 32'h0, 4'h0);
    writes = write_count;
    access(1'b1, 32'h0, 32'h0, 4'h0);
    if (write_count != writes + 2) begin
      stim_errors++;
      $display("%0t: fence wrote %0d words instead of 2", $time, write_count - writes);
    end
    access(1'b0, a, 32'h0, 4'h0);
    access(1'b0, b, 32'h0, 4'h0);

    for (int n = 0; n < random_ops; n++) begin
      kind = int'($urandom % 20);
      addr = base_addr + (($urandom % 256) << 2) + ($urandom % 4);
      wdata = $urandom;
      strb = dtim_pkg::strb_t'(1 + $urandom % 15);
      if (kind == 0) begin
        access(1'b1, 32'h0, 32'h0, 4'h0);
      end else if (kind < 9) begin
        access(1'b0, addr, 32'h0, 4'h0);
      end else if (kind < 16) begin
        access(1'b0, addr, wdata, strb);
      end else begin
        addr = (kind < 18) ? top_addr + (($urandom % 64) << 2)
                           : base_addr - ((1 + $urandom % 64) << 2);
        access(1'b0, addr, wdata, kind[0] ? strb : 4'h0);
      end
    end
    access(1'b1, 32'h0, 32'h0, 4'h0);

    if (xfer_done != xfer_q.size()) begin
      stim_errors++;
      $display("%0d expected memory transfers never happened", xfer_q.size() - xfer_done);
    end
    if (write_count != expected_writes) begin
      stim_errors++;
      $display("memory saw %0d writes, %0d expected", write_count, expected_writes);
    end
    $display("responses %0d, transfers %0d, check errors %0d, sequence errors %0d",
             responded, xfer_done, errors, stim_errors);
    if (errors + stim_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/dtim_pkg.sv
logic/dtim_ram_if.sv
logic/dtim_req_if.sv
logic/dtim_ram.sv
logic/dtim_decode.sv
logic/dtim_execute.sv
logic/dtim_top.sv
verification/dtim_mem_model.sv
verification/tb_dtim.sv
